// ==== hw/cp0_cfg.svh ====
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

`define CP0_DATA_W 32

// Register address is {rd, sel}
`define CP0_ADDR_BADVADDR {5'd8, 3'd0}
`define CP0_ADDR_COUNT    {5'd9, 3'd0}
`define CP0_ADDR_COMPARE  {5'd11, 3'd0}
`define CP0_ADDR_STATUS   {5'd12, 3'd0}
`define CP0_ADDR_CAUSE    {5'd13, 3'd0}
`define CP0_ADDR_EPC      {5'd14, 3'd0}
`define CP0_ADDR_PRID     {5'd15, 3'd0}
`define CP0_ADDR_CONFIG   {5'd16, 3'd0}

`define CP0_PRID_VAL         32'h0000_4220
`define CP0_CONFIG_RESET     32'h8000_0083 // M set, MT 1, K0 cached
`define CP0_STATUS_BEV_RESET 1'b1
`define CP0_EPC_BD_OFFSET    32'd4

// Writable field positions
`define CP0_STATUS_CU0 28
`define CP0_STATUS_BEV 22
`define CP0_STATUS_IM  15:8
`define CP0_STATUS_UM  4
`define CP0_STATUS_ERL 2
`define CP0_STATUS_EXL 1
`define CP0_STATUS_IE  0
`define CP0_CAUSE_IP_SW 9:8
`define CP0_CONFIG_K0  2:0

// Architectural ExcCode values
`define CP0_EXC_INT  5'd0
`define CP0_EXC_ADEL 5'd4
`define CP0_EXC_ADES 5'd5
`define CP0_EXC_SYS  5'd8
`define CP0_EXC_BP   5'd9
`define CP0_EXC_RI   5'd10
`define CP0_EXC_CPU  5'd11
`define CP0_EXC_OV   5'd12
`define CP0_EXC_TRAP 5'd13

`endif

// ==== hw/cp0_pkg.sv ====
`include "cp0_cfg.svh"

package cp0_pkg;

    // Exception kind as reported by the pipeline
    typedef enum logic [4:0] {
        NONE = 5'd0,
        INT,
        ADEL,
        ADES,
        SYS,
        BP,
        RI,
        CPU,
        OV,
        TRAP
    } exc_type_e;

    // Instruction sitting in the memory stage
    typedef struct packed {
        logic                   valid;
        logic                   inst_mtc0;
        logic                   inst_eret;
        logic                   ex;         // Exception flagged upstream
        logic                   bd;         // In a branch delay slot
        exc_type_e              exc_type;
        logic [4:0]             rd;
        logic [2:0]             sel;
        logic [`CP0_DATA_W-1:0] alu_result; // mtc0 data or data address
        logic [`CP0_DATA_W-1:0] pc;
    } mem_req_t;

    // One-hot register select
    typedef struct packed {
        logic badvaddr;
        logic count;
        logic compare;
        logic status;
        logic cause;
        logic epc;
        logic prid;
        logic config0;
    } reg_sel_t;

    typedef struct packed {
        reg_sel_t               sel;
        logic                   we;
        logic [`CP0_DATA_W-1:0] data;
    } cp0_wr_t;

    // Exception entry or eret this cycle
    typedef struct packed {
        logic                   take;
        logic                   eret;
        logic                   bd;
        logic [4:0]             exc_code;
        logic                   cpu_unusable;
        logic [`CP0_DATA_W-1:0] epc_val;
        logic                   badvaddr_we;
        logic [`CP0_DATA_W-1:0] badvaddr_val;
    } exc_event_t;

endpackage

// ==== hw/cp0_exc_ctrl.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_exc_ctrl (
    input  cp0_pkg::mem_req_t   mem,
    output cp0_pkg::cp0_wr_t    access,
    output cp0_pkg::exc_event_t exc_event,
    output logic                eret_flush
);

    logic [7:0]             addr;
    logic                   addr_err;
    logic                   pc_misaligned;
    logic [4:0]             exc_code;
    cp0_pkg::reg_sel_t      sel_dec;

    assign addr = {mem.rd, mem.sel};

    // Address decode also drives the read mux, so no write qualifier here
    always_comb begin
        sel_dec = '0;
        case (addr)
            `CP0_ADDR_BADVADDR: sel_dec.badvaddr = 1'b1;
            `CP0_ADDR_COUNT:    sel_dec.count    = 1'b1;
            `CP0_ADDR_COMPARE:  sel_dec.compare  = 1'b1;
            `CP0_ADDR_STATUS:   sel_dec.status   = 1'b1;
            `CP0_ADDR_CAUSE:    sel_dec.cause    = 1'b1;
            `CP0_ADDR_EPC:      sel_dec.epc      = 1'b1;
            `CP0_ADDR_PRID:     sel_dec.prid     = 1'b1;
            `CP0_ADDR_CONFIG:   sel_dec.config0  = 1'b1;
            default:            sel_dec          = '0;
        endcase
    end

    assign access.sel  = sel_dec;
    assign access.we   = mem.valid && mem.inst_mtc0 && !mem.ex; // Faulting mtc0 writes nothing
    assign access.data = mem.alu_result;

    // Pipeline exception kind to Cause.ExcCode
    always_comb begin
        case (mem.exc_type)
            cp0_pkg::INT:  exc_code = `CP0_EXC_INT;
            cp0_pkg::ADEL: exc_code = `CP0_EXC_ADEL;
            cp0_pkg::ADES: exc_code = `CP0_EXC_ADES;
            cp0_pkg::SYS:  exc_code = `CP0_EXC_SYS;
            cp0_pkg::BP:   exc_code = `CP0_EXC_BP;
            cp0_pkg::RI:   exc_code = `CP0_EXC_RI;
            cp0_pkg::CPU:  exc_code = `CP0_EXC_CPU;
            cp0_pkg::OV:   exc_code = `CP0_EXC_OV;
            cp0_pkg::TRAP: exc_code = `CP0_EXC_TRAP;
            default:       exc_code = 5'd0;
        endcase
    end

    assign pc_misaligned = (mem.pc[1:0] != 2'b00);
    assign addr_err      = (mem.exc_type == cp0_pkg::ADEL) || (mem.exc_type == cp0_pkg::ADES);

    assign exc_event.take         = mem.valid && mem.ex;
    assign exc_event.eret         = mem.valid && mem.inst_eret && !mem.ex;
    assign exc_event.bd           = mem.bd;
    assign exc_event.exc_code     = exc_code;
    assign exc_event.cpu_unusable = (mem.exc_type == cp0_pkg::CPU);

    // Delay slot faults restart at the branch
    assign exc_event.epc_val = mem.bd ? mem.pc - `CP0_EPC_BD_OFFSET : mem.pc;

    assign exc_event.badvaddr_we = exc_event.take && addr_err;

    // Fetch fault on a bad pc, otherwise the data address
    assign exc_event.badvaddr_val = (mem.exc_type == cp0_pkg::ADEL && pc_misaligned) ?
                                    mem.pc : mem.alu_result;

    assign eret_flush = exc_event.eret;

endmodule

// ==== hw/cp0_timer.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_timer (
    input  logic                   clk,
    input  logic                   reset,
    input  cp0_pkg::cp0_wr_t       access,
    output logic [`CP0_DATA_W-1:0] count,
    output logic [`CP0_DATA_W-1:0] compare,
    output logic                   timer_int
);

    logic tick;
    logic count_we;
    logic compare_we;

    assign count_we   = access.we && access.sel.count;
    assign compare_we = access.we && access.sel.compare;

    // Count runs at half the core clock
    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count_we) begin
            count <= access.data; // Write wins over increment
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '0;
        end else if (compare_we) begin
            compare <= access.data;
        end
    end

    // Writing Compare acknowledges the timer interrupt
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (compare_we) begin
            timer_int <= 1'b0;
        end else if (count == compare) begin
            timer_int <= 1'b1;
        end
    end

endmodule

// ==== hw/cp0_regs.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  cp0_pkg::cp0_wr_t       access,
    input  cp0_pkg::exc_event_t    exc_event,
    input  logic [5:0]             ext_int,
    input  logic [`CP0_DATA_W-1:0] count,
    input  logic [`CP0_DATA_W-1:0] compare,
    input  logic                   timer_int,
    output logic [`CP0_DATA_W-1:0] rdata,
    output logic [`CP0_DATA_W-1:0] epc,
    output logic                   status_exl,
    output logic                   int_req,
    output logic [2:0]             config_k0
);

    localparam logic [`CP0_DATA_W-1:0] CONFIG_RESET_WORD = `CP0_CONFIG_RESET;

    logic                   status_we;
    logic                   cause_we;
    logic                   epc_we;
    logic                   config_we;

    logic                   status_cu0;
    logic                   status_bev;
    logic [7:0]             status_im;
    logic                   status_um;
    logic                   status_erl;
    logic                   status_ie;

    logic                   cause_bd;
    logic [1:0]             cause_ce;
    logic [5:0]             ext_int_q;
    logic [1:0]             cause_ip_sw;
    logic [7:0]             cause_ip;
    logic [4:0]             cause_exc_code;

    logic [`CP0_DATA_W-1:0] badvaddr;
    logic [`CP0_DATA_W-1:0] status_word;
    logic [`CP0_DATA_W-1:0] cause_word;
    logic [`CP0_DATA_W-1:0] config_word;

    assign status_we = access.we && access.sel.status;
    assign cause_we  = access.we && access.sel.cause;
    assign epc_we    = access.we && access.sel.epc;
    assign config_we = access.we && access.sel.config0;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_cu0 <= 1'b0;
            status_bev <= `CP0_STATUS_BEV_RESET;
            status_im  <= '0;
            status_um  <= 1'b0;
            status_erl <= 1'b0;
            status_ie  <= 1'b0;
        end else if (status_we) begin
            status_cu0 <= access.data[`CP0_STATUS_CU0];
            status_bev <= access.data[`CP0_STATUS_BEV];
            status_im  <= access.data[`CP0_STATUS_IM];
            status_um  <= access.data[`CP0_STATUS_UM];
            status_erl <= access.data[`CP0_STATUS_ERL];
            status_ie  <= access.data[`CP0_STATUS_IE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl <= 1'b0;
        end else if (exc_event.take) begin
            status_exl <= 1'b1; // Exception beats eret and mtc0
        end else if (exc_event.eret) begin
            status_exl <= 1'b0;
        end else if (status_we) begin
            status_exl <= access.data[`CP0_STATUS_EXL];
        end
    end

    // EPC and BD only track the outermost exception
    always_ff @(posedge clk) begin
        if (reset) begin
            epc      <= '0;
            cause_bd <= 1'b0;
        end else if (exc_event.take && !status_exl) begin
            epc      <= exc_event.epc_val;
            cause_bd <= exc_event.bd;
        end else if (epc_we) begin
            epc <= access.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_exc_code <= '0;
            cause_ce       <= '0;
        end else if (exc_event.take) begin
            cause_exc_code <= exc_event.exc_code;
            if (exc_event.cpu_unusable) begin
                cause_ce <= 2'd1; // Only CP1 is reported unusable
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr <= '0;
        end else if (exc_event.badvaddr_we) begin
            badvaddr <= exc_event.badvaddr_val;
        end
    end

    // Hardware lines sampled one edge late, software bits by mtc0
    always_ff @(posedge clk) begin
        if (reset) begin
            ext_int_q   <= '0;
            cause_ip_sw <= '0;
        end else begin
            ext_int_q <= ext_int;
            if (cause_we) begin
                cause_ip_sw <= access.data[`CP0_CAUSE_IP_SW];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            config_k0 <= CONFIG_RESET_WORD[`CP0_CONFIG_K0];
        end else if (config_we) begin
            config_k0 <= access.data[`CP0_CONFIG_K0];
        end
    end

    assign cause_ip = {ext_int_q[5] | timer_int, ext_int_q[4:0], cause_ip_sw}; // Timer shares IP7

    assign int_req = (|(cause_ip & status_im)) && status_ie && !status_exl;

    assign status_word = {3'b0, status_cu0, 5'b0, status_bev, 6'b0, status_im,
                          3'b0, status_um, 1'b0, status_erl, status_exl, status_ie};
    assign cause_word  = {cause_bd, timer_int, cause_ce, 12'b0, cause_ip,
                          1'b0, cause_exc_code, 2'b0};
    assign config_word = {CONFIG_RESET_WORD[`CP0_DATA_W-1:3], config_k0};

    // mfc0 read mux on the one-hot select
    always_comb begin
        rdata = '0;
        if (access.sel.badvaddr) rdata = badvaddr;
        if (access.sel.count)    rdata = count;
        if (access.sel.compare)  rdata = compare;
        if (access.sel.status)   rdata = status_word;
        if (access.sel.cause)    rdata = cause_word;
        if (access.sel.epc)      rdata = epc;
        if (access.sel.prid)     rdata = `CP0_PRID_VAL;
        if (access.sel.config0)  rdata = config_word;
    end

endmodule

// ==== hw/cp0_top.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_top (
    input  logic                   clk,
    input  logic                   reset,
    input  cp0_pkg::mem_req_t      mem,
    input  logic [5:0]             ext_int,
    output logic [`CP0_DATA_W-1:0] rdata,
    output logic                   eret_flush,
    output logic [`CP0_DATA_W-1:0] epc,
    output logic                   status_exl,
    output logic                   int_req,
    output logic [2:0]             config_k0
);

    cp0_pkg::cp0_wr_t       access;
    cp0_pkg::exc_event_t    exc_event;
    logic [`CP0_DATA_W-1:0] count;
    logic [`CP0_DATA_W-1:0] compare;
    logic                   timer_int;

    // Memory stage decode
    cp0_exc_ctrl u_exc_ctrl (
        .mem        (mem),
        .access     (access),
        .exc_event  (exc_event),
        .eret_flush (eret_flush)
    );

    cp0_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .access    (access),
        .count     (count),
        .compare   (compare),
        .timer_int (timer_int)
    );

    cp0_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .exc_event  (exc_event),
        .ext_int    (ext_int),
        .count      (count),
        .compare    (compare),
        .timer_int  (timer_int),
        .rdata      (rdata),
        .epc        (epc),
        .status_exl (status_exl),
        .int_req    (int_req),
        .config_k0  (config_k0)
    );

endmodule

// ==== tests/cp0_asserts.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_asserts (
    input logic                   clk,
    input logic                   reset,
    input cp0_pkg::cp0_wr_t       access,
    input cp0_pkg::exc_event_t    exc_event,
    input logic [`CP0_DATA_W-1:0] epc,
    input logic                   status_exl,
    input logic                   int_req
);

    int fail_count = 0;

    // eret alone returns to normal level
    eret_clears_exl: assert property (@(posedge clk) disable iff (reset)
        (exc_event.eret && !exc_event.take) |=> !status_exl)
        else begin
            $error("EXL still set after eret");
            fail_count++;
        end

    // Exception entry raises EXL, which masks interrupts
    no_int_in_exl: assert property (@(posedge clk) disable iff (reset)
        exc_event.take |=> (status_exl && !int_req))
        else begin
            $error("EXL clear or int_req high after exception entry");
            fail_count++;
        end

    // Only outer exception entry or an mtc0 may move EPC
    epc_change_cause: assert property (@(posedge clk) disable iff (reset)
        (epc != $past(epc)) |->
            $past((exc_event.take && !status_exl) || (access.we && access.sel.epc)))
        else begin
            $error("EPC changed without exception or mtc0");
            fail_count++;
        end

endmodule

bind cp0_regs cp0_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .access     (access),
    .exc_event  (exc_event),
    .epc        (epc),
    .status_exl (status_exl),
    .int_req    (int_req)
);

// ==== tests/cp0_tb.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_tb;

    localparam int NUM_CYCLES     = 4000;
    localparam int TIMEOUT_CYCLES = 6000;

    logic              clk;
    logic              reset;
    cp0_pkg::mem_req_t mem;
    logic [5:0]        ext_int;
    logic [31:0]       rdata;
    logic              eret_flush;
    logic [31:0]       epc;
    logic              status_exl;
    logic              int_req;
    logic [2:0]        config_k0;

    // Reference copy of the CP0 state
    logic        m_cu0;
    logic        m_bev;
    logic [7:0]  m_im;
    logic        m_um;
    logic        m_erl;
    logic        m_exl;
    logic        m_ie;
    logic        m_bd;
    logic [1:0]  m_ce;
    logic [5:0]  m_ext_q;
    logic [1:0]  m_ip_sw;
    logic [4:0]  m_exc_code;
    logic [31:0] m_epc;
    logic [31:0] m_badvaddr;
    logic [2:0]  m_k0;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic        m_ti;
    logic        m_tick;

    int          errors;
    int          cycle;

    cp0_top DUT (
        .clk        (clk),
        .reset      (reset),
        .mem        (mem),
        .ext_int    (ext_int),
        .rdata      (rdata),
        .eret_flush (eret_flush),
        .epc        (epc),
        .status_exl (status_exl),
        .int_req    (int_req),
        .config_k0  (config_k0)
    );

    always #10 clk = ~clk;

    function automatic logic [4:0] exc_code_of(cp0_pkg::exc_type_e t);
        case (t)
            cp0_pkg::ADEL: return 5'd4;
            cp0_pkg::ADES: return 5'd5;
            cp0_pkg::SYS:  return 5'd8;
            cp0_pkg::BP:   return 5'd9;
            cp0_pkg::RI:   return 5'd10;
            cp0_pkg::CPU:  return 5'd11;
            cp0_pkg::OV:   return 5'd12;
            cp0_pkg::TRAP: return 5'd13;
            default:       return 5'd0; // INT and NONE
        endcase
    endfunction

    function automatic logic [7:0] ip_expected();
        return {m_ext_q[5] | m_ti, m_ext_q[4:0], m_ip_sw};
    endfunction

    function automatic logic [31:0] read_expected(logic [7:0] addr);
        case (addr)
            `CP0_ADDR_BADVADDR: return m_badvaddr;
            `CP0_ADDR_COUNT:    return m_count;
            `CP0_ADDR_COMPARE:  return m_compare;
            `CP0_ADDR_STATUS:   return {3'b0, m_cu0, 5'b0, m_bev, 6'b0, m_im,
                                        3'b0, m_um, 1'b0, m_erl, m_exl, m_ie};
            `CP0_ADDR_CAUSE:    return {m_bd, m_ti, m_ce, 12'b0, ip_expected(),
                                        1'b0, m_exc_code, 2'b0};
            `CP0_ADDR_EPC:      return m_epc;
            `CP0_ADDR_PRID:     return `CP0_PRID_VAL;
            `CP0_ADDR_CONFIG:   return {`CP0_CONFIG_RESET & 32'hffff_fff8} | {29'b0, m_k0};
            default:            return 32'h0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        assert (got === expected) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic reset_model();
        m_cu0      = 1'b0;
        m_bev      = `CP0_STATUS_BEV_RESET;
        m_im       = '0;
        m_um       = 1'b0;
        m_erl      = 1'b0;
        m_exl      = 1'b0;
        m_ie       = 1'b0;
        m_bd       = 1'b0;
        m_ce       = '0;
        m_ext_q    = '0;
        m_ip_sw    = '0;
        m_exc_code = '0;
        m_epc      = '0;
        m_badvaddr = '0;
        m_k0       = 3'd3;
        m_count    = '0;
        m_compare  = '0;
        m_ti       = 1'b0;
        m_tick     = 1'b0;
    endtask

    task automatic drive_random();
        int         kind;
        logic [7:0] addr;
        kind = $urandom_range(0, 99);
        mem = '0;
        mem.valid = ($urandom_range(0, 9) != 0);
        if ($urandom_range(0, 99) < 85) begin // Mostly implemented registers
            case ($urandom_range(0, 7))
                0:       addr = `CP0_ADDR_BADVADDR;
                1:       addr = `CP0_ADDR_COUNT;
                2:       addr = `CP0_ADDR_COMPARE;
                3:       addr = `CP0_ADDR_STATUS;
                4:       addr = `CP0_ADDR_CAUSE;
                5:       addr = `CP0_ADDR_EPC;
                6:       addr = `CP0_ADDR_PRID;
                default: addr = `CP0_ADDR_CONFIG;
            endcase
        end else begin
            addr = $urandom_range(0, 255);
        end
        mem.rd         = addr[7:3];
        mem.sel        = addr[2:0];
        mem.alu_result = $urandom;
        if (addr == `CP0_ADDR_COMPARE && $urandom_range(0, 1) == 1) begin
            mem.alu_result = m_count + $urandom_range(0, 8); // Land just ahead of Count
        end
        mem.pc = $urandom;
        if ($urandom_range(0, 3) != 0) begin
            mem.pc[1:0] = 2'b00;
        end
        mem.bd       = $urandom_range(0, 1);
        mem.exc_type = cp0_pkg::NONE;
        if (kind < 45) begin
            mem.inst_mtc0 = 1'b1;
        end else if (kind < 50) begin // Rare exception, maybe on an mtc0 or eret
            mem.ex        = 1'b1;
            mem.exc_type  = cp0_pkg::exc_type_e'($urandom_range(1, 9));
            mem.inst_mtc0 = $urandom_range(0, 1);
            mem.inst_eret = ($urandom_range(0, 3) == 0);
        end else if (kind < 54) begin
            mem.inst_eret = 1'b1;
            mem.inst_mtc0 = ($urandom_range(0, 3) == 0);
        end
        if ($urandom_range(0, 15) == 0) begin
            ext_int = $urandom_range(0, 63);
        end
    endtask

    task automatic check_outputs();
        logic exp_int;
        exp_int = (|(ip_expected() & m_im)) && m_ie && !m_exl;
        assert (DUT.u_regs.u_asserts.fail_count == 0) else begin
            errors++;
            $display("a bound assertion on the register bank failed before %0t ns", $time);
            $display("Simulation FAILED");
            $fatal(1, "assertion failure");
        end
        compare_value("rdata", rdata, read_expected({mem.rd, mem.sel}));
        compare_value("eret_flush", eret_flush, mem.valid && mem.inst_eret && !mem.ex);
        compare_value("epc", epc, m_epc);
        compare_value("status_exl", status_exl, m_exl);
        compare_value("int_req", int_req, exp_int);
        compare_value("config_k0", config_k0, m_k0);
    endtask

    // Applies one rising edge to the model
    task automatic update_model();
        logic [7:0]  addr;
        logic        we;
        logic        take;
        logic        eret;
        logic [31:0] d;
        addr = {mem.rd, mem.sel};
        we   = mem.valid && mem.inst_mtc0 && !mem.ex;
        take = mem.valid && mem.ex;
        eret = mem.valid && mem.inst_eret && !mem.ex;
        d    = mem.alu_result;
        if (we && addr == `CP0_ADDR_COMPARE) begin
            m_ti = 1'b0;
        end else if (m_count == m_compare) begin
            m_ti = 1'b1;
        end
        if (we && addr == `CP0_ADDR_COUNT) begin
            m_count = d;
        end else if (m_tick) begin
            m_count = m_count + 1;
        end
        if (we && addr == `CP0_ADDR_COMPARE) begin
            m_compare = d;
        end
        m_tick  = !m_tick;
        m_ext_q = ext_int;
        if (we && addr == `CP0_ADDR_CAUSE) begin
            m_ip_sw = d[9:8];
        end
        if (we && addr == `CP0_ADDR_STATUS) begin
            m_cu0 = d[28];
            m_bev = d[22];
            m_im  = d[15:8];
            m_um  = d[4];
            m_erl = d[2];
            m_ie  = d[0];
        end
        if (take && !m_exl) begin // Nested exceptions keep EPC and BD
            m_epc = mem.bd ? mem.pc - 32'd4 : mem.pc;
            m_bd  = mem.bd;
        end else if (we && addr == `CP0_ADDR_EPC) begin
            m_epc = d;
        end
        if (take) begin
            m_exc_code = exc_code_of(mem.exc_type);
            if (mem.exc_type == cp0_pkg::CPU) begin
                m_ce = 2'd1;
            end
            if (mem.exc_type == cp0_pkg::ADEL && mem.pc[1:0] != 2'b00) begin
                m_badvaddr = mem.pc;
            end else if (mem.exc_type == cp0_pkg::ADEL || mem.exc_type == cp0_pkg::ADES) begin
                m_badvaddr = d;
            end
        end
        if (take) begin
            m_exl = 1'b1;
        end else if (eret) begin
            m_exl = 1'b0;
        end else if (we && addr == `CP0_ADDR_STATUS) begin
            m_exl = d[1];
        end
        if (we && addr == `CP0_ADDR_CONFIG) begin
            m_k0 = d[2:0];
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        mem     = '0;
        ext_int = '0;
        errors  = 0;
        void'($urandom(32'h58ed));
        reset_model();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset = 1'b0;
        cycle = 0;
        while (cycle < NUM_CYCLES) begin
            drive_random();
            #1;
            check_outputs();
            @(posedge clk);
            update_model();
            @(negedge clk);
            cycle++;
        end
        if (errors == 0 && DUT.u_regs.u_asserts.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checks failed");
        end
    end

    // Watchdog on the whole run
    initial begin
        for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/cp0_pkg.sv
hw/cp0_exc_ctrl.sv
hw/cp0_timer.sv
hw/cp0_regs.sv
hw/cp0_top.sv
tests/cp0_asserts.sv
tests/cp0_tb.sv

// ==== Bender.yml ====
package:
  name: cp0

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cp0_pkg.sv
      - hw/cp0_exc_ctrl.sv
      - hw/cp0_timer.sv
      - hw/cp0_regs.sv
      - hw/cp0_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/cp0_asserts.sv
      - tests/cp0_tb.sv
